//--- Bender.yml
package:
  name: ex_stage

sources:
  - target: rtl
    files:
      - common/ex_pkg.sv
      - logic/alu.sv
      - execute/ex_operand_unit.sv
      - execute/ex_control.sv
      - execute/ex_stage.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/ex_stage_tb.sv

//--- common/ex_pkg.sv
// Execute stage shared definitions
package ex_pkg;

    // Register file index width
    localparam int reg_addr_w = 5;

    // Exact ALU function, picked by decode
    typedef enum logic [4:0] {
        alu_add    = 5'd0,
        alu_sub    = 5'd1,
        alu_sll    = 5'd2,
        alu_slt    = 5'd3,      // Signed compare
        alu_sltu   = 5'd4,      // Unsigned compare
        alu_xor    = 5'd5,
        alu_srl    = 5'd6,
        alu_sra    = 5'd7,      // Sign-filling shift
        alu_or     = 5'd8,
        alu_and    = 5'd9,
        alu_pass_b = 5'd10      // Second operand straight through
    } alu_ctl_t;

    // Instruction class, steers the ALU inputs
    typedef enum logic [2:0] {
        op_load_store = 3'b000, // Address calc, rs1 + imm
        op_branch     = 3'b001, // Compare rs1 against rs2
        op_reg_imm    = 3'b010, // R and I types
        op_lui        = 3'b100,
        op_auipc      = 3'b101,
        op_none       = 3'b111  // Anything else drives zeros
    } alu_op_t;

    // Branch condition, funct3 of the B type
    typedef enum logic [2:0] {
        br_beq  = 3'b000,
        br_bne  = 3'b001,
        br_blt  = 3'b100,
        br_bge  = 3'b101,
        br_bltu = 3'b110,
        br_bgeu = 3'b111
    } branch_t;

endpackage

//--- execute/ex_control.sv
// Execute control and branch decision
`timescale 1ns/1ps

module ex_control
    import ex_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    stall,
    input  logic                    alu_src,
    input  alu_op_t                 alu_op,
    input  alu_ctl_t                alu_ctl,
    input  logic                    mem_write_in,
    input  logic                    mem_read_in,
    input  logic                    reg_write_in,
    input  logic [reg_addr_w-1:0]   reg_dest_in,
    input  logic                    mem_to_reg_in,
    input  logic                    reg_data_src_in,    // Memory or ALU for writeback
    input  logic                    pc_src,             // Decode wants a redirect
    input  branch_t                 branch_type,
    input  logic                    zero,               // ALU flags of the held instruction
    input  logic                    negative,
    input  logic                    borrow,
    input  logic                    overflow,
    output alu_op_t                 alu_op_q,
    output logic                    alu_src_q,
    output alu_ctl_t                alu_ctl_q,
    output logic                    mem_write,
    output logic                    mem_read,
    output logic                    reg_write,
    output logic [reg_addr_w-1:0]   reg_dest,
    output logic                    mem_to_reg,
    output logic                    reg_data_src,
    output logic                    redirect
);
    branch_t    branch_type_q;
    logic       pc_src_q;
    logic       taken;          // Condition of the held branch

    // Control held with the operands
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            alu_op_q      <= op_load_store;     // 0 + 0 out of reset
            alu_src_q     <= 1'b0;
            alu_ctl_q     <= alu_add;
            branch_type_q <= br_beq;
            pc_src_q      <= 1'b0;
            mem_write     <= 1'b0;
            mem_read      <= 1'b0;
            reg_write     <= 1'b0;
            reg_dest      <= '0;
            mem_to_reg    <= 1'b0;
            reg_data_src  <= 1'b0;
        end
        else if (!stall)
        begin
            alu_op_q      <= alu_op;
            alu_src_q     <= alu_src;
            alu_ctl_q     <= alu_ctl;
            branch_type_q <= branch_type;
            pc_src_q      <= pc_src;
            mem_write     <= mem_write_in;     // Memory and writeback fields ride along
            mem_read      <= mem_read_in;
            reg_write     <= reg_write_in;
            reg_dest      <= reg_dest_in;
            mem_to_reg    <= mem_to_reg_in;
            reg_data_src  <= reg_data_src_in;
        end
    end

    // Branch condition from the subtract flags
    always_comb
    begin
        case (branch_type_q)
            br_beq:  taken = zero;
            br_bne:  taken = !zero;
            br_blt:  taken = negative ^ overflow;       // Signed less-than
            br_bge:  taken = !(negative ^ overflow);
            br_bltu: taken = borrow;
            br_bgeu: taken = !borrow;
            default: taken = 1'b0;      // Undefined funct3 never jumps
        endcase
    end

    // Jumps and others redirect on pc_src alone
    assign redirect = (alu_op_q == op_branch) ? (pc_src_q & taken) : pc_src_q;

endmodule

//--- execute/ex_operand_unit.sv
// Execute operand path
`timescale 1ns/1ps

module ex_operand_unit
    import ex_pkg::*;
#(
    parameter int data_w = 32
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    stall,
    input  logic [data_w-1:0]       rs1_value,          // From register file via decode
    input  logic [data_w-1:0]       rs2_value,
    input  logic [data_w-1:0]       imm,
    input  logic [data_w-1:0]       pc,
    input  logic [reg_addr_w-1:0]   rs1_addr,
    input  logic [reg_addr_w-1:0]   rs2_addr,
    input  logic                    ex_mem_reg_write,   // Next stage, newest result
    input  logic [reg_addr_w-1:0]   ex_mem_reg_dest,
    input  logic [data_w-1:0]       ex_mem_value,
    input  logic                    mem_wb_reg_write,   // Two stages on, older result
    input  logic [reg_addr_w-1:0]   mem_wb_reg_dest,
    input  logic [data_w-1:0]       mem_wb_value,
    input  alu_op_t                 alu_op_q,
    input  logic                    alu_src_q,          // 1 picks imm for reg_imm
    output logic [data_w-1:0]       alu_a,
    output logic [data_w-1:0]       alu_b,
    output logic [data_w-1:0]       rs2_fwd,            // Store data downstream
    output logic [data_w-1:0]       branch_target
);
    logic [data_w-1:0] rs1_q;
    logic [data_w-1:0] imm_q;
    logic [data_w-1:0] pc_q;
    logic [data_w-1:0] rs1_sel;     // Forwarded, not yet captured
    logic [data_w-1:0] rs2_sel;

    // Newest producer wins, x0 never forwarded
    function automatic logic [data_w-1:0] fwd_sel(
        input logic [reg_addr_w-1:0]    src,
        input logic [data_w-1:0]        reg_value
    );
        logic ex_mem_hit;
        logic mem_wb_hit;
        ex_mem_hit = ex_mem_reg_write && (ex_mem_reg_dest != '0) && (ex_mem_reg_dest == src);
        mem_wb_hit = mem_wb_reg_write && (mem_wb_reg_dest != '0) && (mem_wb_reg_dest == src);
        if (ex_mem_hit)
            return ex_mem_value;
        else if (mem_wb_hit)
            return mem_wb_value;
        else
            return reg_value;
    endfunction

    always_comb
    begin
        rs1_sel = fwd_sel(rs1_addr, rs1_value);
        rs2_sel = fwd_sel(rs2_addr, rs2_value);
    end

    // Capture on every edge unless stalled
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            rs1_q         <= '0;
            rs2_fwd       <= '0;
            imm_q         <= '0;
            pc_q          <= '0;
            branch_target <= '0;
        end
        else if (!stall)
        begin
            rs1_q         <= rs1_sel;
            rs2_fwd       <= rs2_sel;
            imm_q         <= imm;
            pc_q          <= pc;
            branch_target <= pc + imm;  // Target computed ahead of the ALU
        end
    end

    // ALU input mux by instruction class
    always_comb
    begin
        case (alu_op_q)
            op_load_store:
            begin
                alu_a = rs1_q;
                alu_b = imm_q;
            end
            op_branch:
            begin
                alu_a = rs1_q;      // Compared by subtraction
                alu_b = rs2_fwd;
            end
            op_reg_imm:
            begin
                alu_a = rs1_q;
                alu_b = alu_src_q ? imm_q : rs2_fwd;
            end
            op_lui:
            begin
                alu_a = imm_q;      // Upper immediate as is
                alu_b = '0;
            end
            op_auipc:
            begin
                alu_a = pc_q;
                alu_b = imm_q;
            end
            default:
            begin
                alu_a = '0;
                alu_b = '0;
            end
        endcase
    end

endmodule

//--- execute/ex_stage.sv
// RV32I execute stage
`timescale 1ns/1ps

module ex_stage
    import ex_pkg::*;
#(
    parameter int data_w = 32
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    stall,
    input  logic [data_w-1:0]       rs1_value,
    input  logic [data_w-1:0]       rs2_value,
    input  logic [data_w-1:0]       imm,
    input  logic [data_w-1:0]       pc,
    input  logic [reg_addr_w-1:0]   rs1_addr,
    input  logic [reg_addr_w-1:0]   rs2_addr,
    input  logic                    alu_src,
    input  alu_op_t                 alu_op,
    input  alu_ctl_t                alu_ctl,
    input  logic                    mem_write_in,
    input  logic                    mem_read_in,
    input  logic                    reg_write_in,
    input  logic [reg_addr_w-1:0]   reg_dest_in,
    input  logic                    mem_to_reg_in,
    input  logic                    reg_data_src_in,
    input  logic                    pc_src,
    input  branch_t                 branch_type,
    input  logic                    ex_mem_reg_write,
    input  logic [reg_addr_w-1:0]   ex_mem_reg_dest,
    input  logic [data_w-1:0]       ex_mem_value,
    input  logic                    mem_wb_reg_write,
    input  logic [reg_addr_w-1:0]   mem_wb_reg_dest,
    input  logic [data_w-1:0]       mem_wb_value,
    output logic                    mem_write,
    output logic                    mem_read,
    output logic                    reg_write,
    output logic [reg_addr_w-1:0]   reg_dest,
    output logic                    mem_to_reg,
    output logic                    reg_data_src,
    output logic                    redirect,       // Take branch_target next
    output logic [data_w-1:0]       branch_target,
    output logic [data_w-1:0]       rs2_fwd,
    output logic [data_w-1:0]       result
);
    alu_op_t            alu_op_q;
    logic               alu_src_q;
    alu_ctl_t           alu_ctl_q;
    logic [data_w-1:0]  alu_a;
    logic [data_w-1:0]  alu_b;
    logic               zero;
    logic               negative;
    logic               borrow;
    logic               overflow;

    ex_control ctrl_i (
        .clk             (clk),
        .rst             (rst),
        .stall           (stall),
        .alu_src         (alu_src),
        .alu_op          (alu_op),
        .alu_ctl         (alu_ctl),
        .mem_write_in    (mem_write_in),
        .mem_read_in     (mem_read_in),
        .reg_write_in    (reg_write_in),
        .reg_dest_in     (reg_dest_in),
        .mem_to_reg_in   (mem_to_reg_in),
        .reg_data_src_in (reg_data_src_in),
        .pc_src          (pc_src),
        .branch_type     (branch_type),
        .zero            (zero),
        .negative        (negative),
        .borrow          (borrow),
        .overflow        (overflow),
        .alu_op_q        (alu_op_q),
        .alu_src_q       (alu_src_q),
        .alu_ctl_q       (alu_ctl_q),
        .mem_write       (mem_write),
        .mem_read        (mem_read),
        .reg_write       (reg_write),
        .reg_dest        (reg_dest),
        .mem_to_reg      (mem_to_reg),
        .reg_data_src    (reg_data_src),
        .redirect        (redirect)
    );

    // Forwarding, operand registers and input mux
    ex_operand_unit #(
        .data_w (data_w)
    ) opnd_i (
        .clk              (clk),
        .rst              (rst),
        .stall            (stall),
        .rs1_value        (rs1_value),
        .rs2_value        (rs2_value),
        .imm              (imm),
        .pc               (pc),
        .rs1_addr         (rs1_addr),
        .rs2_addr         (rs2_addr),
        .ex_mem_reg_write (ex_mem_reg_write),
        .ex_mem_reg_dest  (ex_mem_reg_dest),
        .ex_mem_value     (ex_mem_value),
        .mem_wb_reg_write (mem_wb_reg_write),
        .mem_wb_reg_dest  (mem_wb_reg_dest),
        .mem_wb_value     (mem_wb_value),
        .alu_op_q         (alu_op_q),
        .alu_src_q        (alu_src_q),
        .alu_a            (alu_a),
        .alu_b            (alu_b),
        .rs2_fwd          (rs2_fwd),
        .branch_target    (branch_target)
    );

    alu #(
        .data_w (data_w)
    ) alu_i (
        .ctl      (alu_ctl_q),
        .a        (alu_a),
        .b        (alu_b),
        .result   (result),
        .zero     (zero),
        .negative (negative),
        .borrow   (borrow),
        .overflow (overflow)
    );

endmodule

//--- logic/alu.sv
// Integer ALU
`timescale 1ns/1ps

module alu
    import ex_pkg::*;
#(
    parameter int data_w = 32
) (
    input  alu_ctl_t            ctl,
    input  logic [data_w-1:0]   a,
    input  logic [data_w-1:0]   b,
    output logic [data_w-1:0]   result,
    output logic                zero,       // Result is all zeros
    output logic                negative,   // Result sign bit
    output logic                borrow,     // a < b unsigned
    output logic                overflow    // Signed overflow of a - b
);
    localparam int sh_w = $clog2(data_w);   // 5 for RV32

    logic [data_w:0]    diff_ext;           // a - b with carry out on top
    logic [data_w-1:0]  diff;
    logic [sh_w-1:0]    shamt;
    logic               signed_lt;

    // Subtract as a + ~b + 1 so the carry out is visible
    assign diff_ext = {1'b0, a} + {1'b0, ~b} + {{data_w{1'b0}}, 1'b1};
    assign diff     = diff_ext[data_w-1:0];

    // No carry out means the subtraction borrowed
    assign borrow = ~diff_ext[data_w];

    // Operands of differing sign and result sign flipped from a
    assign overflow = (a[data_w-1] ^ b[data_w-1]) & (diff[data_w-1] ^ a[data_w-1]);

    assign signed_lt = diff[data_w-1] ^ overflow;   // True signed less-than
    assign shamt     = b[sh_w-1:0];                 // Low bits of b only

    always_comb
    begin
        case (ctl)
            alu_add:    result = a + b;
            alu_sub:    result = diff;
            alu_sll:    result = a << shamt;
            alu_slt:    result = {{(data_w-1){1'b0}}, signed_lt};
            alu_sltu:   result = {{(data_w-1){1'b0}}, borrow};
            alu_xor:    result = a ^ b;
            alu_srl:    result = a >> shamt;
            alu_sra:    result = $signed(a) >>> shamt;
            alu_or:     result = a | b;
            alu_and:    result = a & b;
            alu_pass_b: result = b;
            default:    result = '0;    // Unused codes
        endcase
    end

    // Flags follow whatever the ALU produced
    assign zero     = (result == '0);
    assign negative = result[data_w-1];

endmodule

//--- verif/ex_model.svh
// Execute stage reference model
`ifndef ex_model_svh
`define ex_model_svh

// Newer stage first, x0 never forwarded
function automatic logic [31:0] fwd_value(
    input logic [4:0]  src,
    input logic [31:0] reg_value,
    input logic        em_we,
    input logic [4:0]  em_dest,
    input logic [31:0] em_value,
    input logic        mw_we,
    input logic [4:0]  mw_dest,
    input logic [31:0] mw_value
);
    if (em_we && em_dest == src && src != '0)
        return em_value;
    if (mw_we && mw_dest == src && src != '0)
        return mw_value;
    return reg_value;   // Register file value
endfunction

function automatic logic [31:0] operand_a(input alu_op_t op, input logic [31:0] rs1,
                                          input logic [31:0] imm, input logic [31:0] pc);
    case (op)
        op_load_store, op_branch, op_reg_imm: return rs1;
        op_lui:   return imm;
        op_auipc: return pc;
        default:  return '0;
    endcase
endfunction

function automatic logic [31:0] operand_b(input alu_op_t op, input logic use_imm,
                                          input logic [31:0] rs2, input logic [31:0] imm);
    case (op)
        op_load_store, op_auipc: return imm;
        op_branch:  return rs2;
        op_reg_imm: return use_imm ? imm : rs2;
        default:    return '0;  // lui and none
    endcase
endfunction

function automatic logic [31:0] alu_value(input alu_ctl_t ctl, input logic [31:0] a,
                                          input logic [31:0] b);
    case (ctl)
        alu_add:    return a + b;
        alu_sub:    return a - b;
        alu_sll:    return a << b[4:0];
        alu_slt:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        alu_sltu:   return (a < b) ? 32'd1 : 32'd0;
        alu_xor:    return a ^ b;
        alu_srl:    return a >> b[4:0];
        alu_sra:    return $signed(a) >>> b[4:0];
        alu_or:     return a | b;
        alu_and:    return a & b;
        alu_pass_b: return b;
        default:    return '0;
    endcase
endfunction

// Plain comparisons, no ALU flags
function automatic logic redirect_value(input alu_op_t op, input logic pc_src,
                                        input branch_t bt, input logic [31:0] a,
                                        input logic [31:0] b);
    logic cond;
    case (bt)
        br_beq:  cond = (a == b);
        br_bne:  cond = (a != b);
        br_blt:  cond = ($signed(a) < $signed(b));
        br_bge:  cond = ($signed(a) >= $signed(b));
        br_bltu: cond = (a < b);
        br_bgeu: cond = (a >= b);
        default: cond = 1'b0;
    endcase
    return (op == op_branch) ? (pc_src & cond) : pc_src;
endfunction

`endif

//--- verif/ex_stage_tb.sv
// Execute stage testbench
`timescale 1ns/1ps

module ex_stage_tb
    import ex_pkg::*;
();
    localparam int n_reset  = 4;
    localparam int n_arith  = 200;
    localparam int n_fwd    = 150;
    localparam int n_branch = 96;      // 6 types, 2 pc_src, 8 operand pairs
    localparam int n_stall  = 100;     // 20 issues, up to 4 held cycles each
    localparam int n_ctrl   = 100;
    localparam int timeout_cycles = n_reset + n_arith + n_fwd + n_branch + n_stall + n_ctrl + 50;

    logic clk, rst, stall, alu_src, pc_src;
    logic [31:0] rs1_value, rs2_value, imm, pc, ex_mem_value, mem_wb_value;
    logic [4:0] rs1_addr, rs2_addr, reg_dest_in, ex_mem_reg_dest, mem_wb_reg_dest;
    alu_op_t alu_op;
    alu_ctl_t alu_ctl;
    branch_t branch_type;
    logic mem_write_in, mem_read_in, reg_write_in, mem_to_reg_in, reg_data_src_in;
    logic ex_mem_reg_write, mem_wb_reg_write;
    logic mem_write, mem_read, reg_write, mem_to_reg, reg_data_src, redirect;
    logic [4:0] reg_dest;
    logic [31:0] branch_target, rs2_fwd, result;

    // Expected outputs start at their reset values
    logic [31:0] exp_result = '0, exp_target = '0, exp_rs2 = '0;
    logic exp_redirect = 0, exp_mem_write = 0, exp_mem_read = 0, exp_reg_write = 0;
    logic exp_mem_to_reg = 0, exp_reg_data_src = 0;
    logic [4:0] exp_reg_dest = '0;

    logic [31:0] lfsr_state = 32'd98176;
    int error_count = 0;
    int check_count = 0;
    int cycle_count;
    alu_op_t op_list [6] = '{op_load_store, op_reg_imm, op_lui, op_auipc, op_branch, op_none};
    branch_t br_list [6] = '{br_beq, br_bne, br_blt, br_bge, br_bltu, br_bgeu};
    // Equal, signed and unsigned boundary pairs
    logic [31:0] pair_a [8] = '{32'd5, 32'd0, 32'hffffffff, 32'h7fffffff, 32'h80000000,
                                32'd1, 32'd2, 32'h80000000};
    logic [31:0] pair_b [8] = '{32'd5, 32'hffffffff, 32'd0, 32'h80000000, 32'h7fffffff,
                                32'd2, 32'd1, 32'h80000000};

    `include "ex_model.svh"

    ex_stage #(.data_w(32)) dut_i (.*);

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;     // 8 ns period
    end

    // Fibonacci LFSR on taps 32 22 2 1 stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic fb;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    task automatic randomize_inputs();
        rs1_value = rand_bits(32);
        rs2_value = rand_bits(32);
        imm = rand_bits(32);
        pc = rand_bits(32);
        rs1_addr = 5'(rand_bits(5));
        rs2_addr = 5'(rand_bits(5));
        alu_src = 1'(rand_bits(1));
        alu_op = op_list[rand_bits(3) % 6];
        alu_ctl = alu_ctl_t'(5'(rand_bits(4) % 11));
        if (alu_op == op_branch)
            alu_ctl = alu_sub;     // Compare by subtraction
        {mem_write_in, mem_read_in, reg_write_in} = 3'(rand_bits(3));
        {mem_to_reg_in, reg_data_src_in, pc_src} = 3'(rand_bits(3));
        reg_dest_in = 5'(rand_bits(5));
        branch_type = br_list[rand_bits(3) % 6];
        ex_mem_reg_write = 1'(rand_bits(1));
        ex_mem_reg_dest = 5'(rand_bits(5));
        ex_mem_value = rand_bits(32);
        mem_wb_reg_write = 1'(rand_bits(1));
        mem_wb_reg_dest = 5'(rand_bits(5));
        mem_wb_value = rand_bits(32);
    endtask

    task automatic check_value(input string test, input string field,
                               input logic [31:0] exp, input logic [31:0] act);
        check_count++;
        assert (act === exp)
        else
        begin
            error_count++;
            $display("ERROR %s %s: expected %h, actual %h", test, field, exp, act);
        end
    endtask

    task automatic check_outputs(input string test);
        check_value(test, "mem_write", 32'(exp_mem_write), 32'(mem_write));
        check_value(test, "mem_read", 32'(exp_mem_read), 32'(mem_read));
        check_value(test, "reg_write", 32'(exp_reg_write), 32'(reg_write));
        check_value(test, "reg_dest", 32'(exp_reg_dest), 32'(reg_dest));
        check_value(test, "mem_to_reg", 32'(exp_mem_to_reg), 32'(mem_to_reg));
        check_value(test, "reg_data_src", 32'(exp_reg_data_src), 32'(reg_data_src));
        check_value(test, "redirect", 32'(exp_redirect), 32'(redirect));
        check_value(test, "branch_target", exp_target, branch_target);
        check_value(test, "rs2_fwd", exp_rs2, rs2_fwd);
        check_value(test, "result", exp_result, result);
    endtask

    // One clock with the current inputs, outputs checked 1 ns after the edge
    task automatic issue(input string test, input logic hold);
        logic [31:0] rs1_f;
        stall = hold;
        if (!hold)
        begin
            rs1_f = fwd_value(rs1_addr, rs1_value, ex_mem_reg_write, ex_mem_reg_dest,
                              ex_mem_value, mem_wb_reg_write, mem_wb_reg_dest, mem_wb_value);
            exp_rs2 = fwd_value(rs2_addr, rs2_value, ex_mem_reg_write, ex_mem_reg_dest,
                                ex_mem_value, mem_wb_reg_write, mem_wb_reg_dest, mem_wb_value);
            exp_result = alu_value(alu_ctl, operand_a(alu_op, rs1_f, imm, pc),
                                   operand_b(alu_op, alu_src, exp_rs2, imm));
            exp_redirect = redirect_value(alu_op, pc_src, branch_type, rs1_f, exp_rs2);
            exp_target = pc + imm;
            {exp_mem_write, exp_mem_read, exp_reg_write} = {mem_write_in, mem_read_in, reg_write_in};
            {exp_mem_to_reg, exp_reg_data_src} = {mem_to_reg_in, reg_data_src_in};
            exp_reg_dest = reg_dest_in;
        end
        @(posedge clk);
        #1;
        check_outputs(test);
    endtask

    initial
    begin
        rst = 1'b1;
        stall = 1'b0;
        randomize_inputs();        // Every input known at time 0
        repeat (3)
        begin
            @(posedge clk);
            #1;
            check_outputs("reset");
        end
        rst = 1'b0;
        randomize_inputs();
        issue("reset", 1'b1);      // First edge after release keeps the reset state
        for (int i = 0; i < n_arith; i++)
        begin
            randomize_inputs();
            alu_op = op_list[rand_bits(2)];    // load_store, reg_imm, lui, auipc
            issue("arith", 1'b0);
        end
        for (int i = 0; i < n_fwd; i++)
        begin
            randomize_inputs();
            alu_op = op_reg_imm;
            alu_src = 1'b0;        // Both sources reach the ALU
            rs1_addr = 5'(rand_bits(2));       // Small address set gives many matches
            rs2_addr = 5'(rand_bits(2));
            ex_mem_reg_dest = 5'(rand_bits(2));
            mem_wb_reg_dest = 5'(rand_bits(2));
            issue("forwarding", 1'b0);
        end
        for (int t = 0; t < 6; t++)
            for (int p = 0; p < 2; p++)
                for (int k = 0; k < 8; k++)
                begin
                    randomize_inputs();
                    alu_op = op_branch;
                    alu_ctl = alu_sub;
                    branch_type = br_list[t];
                    pc_src = p[0];
                    rs1_value = pair_a[k];
                    rs2_value = pair_b[k];
                    ex_mem_reg_write = 1'b0;   // Exact boundary operands
                    mem_wb_reg_write = 1'b0;
                    issue("branch", 1'b0);
                end
        for (int i = 0; i < 20; i++)
        begin
            randomize_inputs();
            issue("stall", 1'b0);
            repeat (1 + rand_bits(2))
            begin
                randomize_inputs();    // Inputs move, outputs must not
                issue("stall", 1'b1);
            end
        end
        for (int i = 0; i < n_ctrl; i++)
        begin
            randomize_inputs();
            issue("control", 1'b0);
        end
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

    initial
    begin
        cycle_count = 0;
        while (cycle_count < timeout_cycles)
        begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Run stopped at cycle limit %0d, tests did not finish", timeout_cycles);
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        $display("Something failed");
        $finish;
    end

endmodule

//--- vlog.f
+incdir+verif
common/ex_pkg.sv
logic/alu.sv
execute/ex_operand_unit.sv
execute/ex_control.sv
execute/ex_stage.sv
verif/ex_stage_tb.sv
